// ==== tb/program_input.txt ====
# test <name> <back-pressure 0/1>, then <word count> <words in hex>,
# then <commit count> <rd data> pairs in hex, in commit order
test addi_imm 0
6  84000005 8800fffd 8c007fff 90008000 94001234 c0000000
5  1 00000005  2 fffffffd  3 00007fff  4 ffff8000  5 00001234

test dep_chain 0
9  84000007 88000003 0c480000 50c40000 150c0000 58940000 1d980000 85c00064
   c0000000
8  1 00000007  2 00000003  3 0000000a  4 00000003  5 0000000d
   6 fffffff6  7 ffffffec  1 00000050

test reg_zero 0
7  84000004 80000009 00440000 08040000 8c000011 50040000 c0000000
6  1 00000004  0 00000009  0 00000008  2 00000004  3 00000011  4 fffffffc

test back_pressure 1
9  84000007 88000003 0c480000 50c40000 150c0000 58940000 1d980000 85c00064
   c0000000
8  1 00000007  2 00000003  3 0000000a  4 00000003  5 0000000d
   6 fffffff6  7 ffffffec  1 00000050

test long_reuse 0
16 84000001 88000002 04480000 08480000 04480000 08480000 04480000 08480000
   04480000 08480000 4c840000 8440ffc9 10c40000 84400100 14480000 c0000000
15 1 00000001  2 00000002  1 00000003  2 00000005  1 00000008  2 0000000d
   1 00000015  2 00000022  1 00000037  2 00000059  3 00000022  1 00000000
   4 00000022  1 00000100  5 00000159

test reload 0
3  9800ffff 1d980000 c0000000
2  6 ffffffff  7 fffffffe

// ==== compile.f ====
design/ooo_pkg.sv
design/inst_mem.sv
design/register_file.sv
design/rob.sv
design/add_sub.sv
design/ooo_core.sv
tb/ooo_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := ooo_core_tb
FILELIST := compile.f
FLAGS := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR := obj_dir
PASS_MSG := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/ooo_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb;
	import ooo_pkg::*;

	localparam int clk_half = 2;
	localparam int drive_delay = 1;
	localparam int cycles_per_word = 200;

	logic clk;
	logic rst_n;
	logic [xlen-1:0] load_data;
	logic load_valid;
	logic start;
	logic commit_ready;
	logic load_ready;
	commit_t commit;
	logic commit_valid;
	logic done;

	// test table filled from the data file
	logic [8*32-1:0] test_name [$];
	int test_bp [$];
	int word_first [$];
	int word_count [$];
	int exp_first [$];
	int exp_count [$];
	logic [xlen-1:0] words [$];
	commit_t expected [$];

	int total_words;
	bit parsed;
	bit hung;
	int errors;
	int checks;
	int passed;
	int failed;

	ooo_core #(
		.rob_width(default_rob_width),
		.inst_mem_width(default_inst_mem_width),
		.rs_depth(default_rs_depth)
	) dut_i (
		.clk,
		.rst_n,
		.load_data,
		.load_valid,
		.start,
		.commit_ready,
		.load_ready,
		.commit,
		.commit_valid,
		.done
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////

	// on to the drive point after the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic read_tests(output bit ok);
		int fd;
		int r;
		int n;
		int bp;
		bit bad;
		logic [8*64-1:0] tok;
		logic [8*256-1:0] line;
		logic [8*32-1:0] name;
		logic [31:0] v1;
		logic [31:0] v2;
		commit_t c;
		ok = 1'b0;
		total_words = 0;
		fd = $fopen("tb/program_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/program_input.txt");
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok[8*64-1:8] == '0 && tok[7:0] == "#") begin
				r = $fgets(line, fd);
			end else if (tok[8*64-1:32] == '0 && tok[31:0] == "test") begin
				r = $fscanf(fd, "%s %d", name, bp);
				bad = r != 2;
				test_name.push_back(name);
				test_bp.push_back(bp);
				word_first.push_back(words.size());
				r = $fscanf(fd, "%d", n);
				bad |= r != 1;
				word_count.push_back(n);
				total_words += n;
				for (int k = 0; k < n; k++) begin
					r = $fscanf(fd, "%h", v1);
					bad |= r != 1;
					words.push_back(v1);
				end
				exp_first.push_back(expected.size());
				r = $fscanf(fd, "%d", n);
				bad |= r != 1;
				exp_count.push_back(n);
				for (int k = 0; k < n; k++) begin
					r = $fscanf(fd, "%h %h", v1, v2);
					bad |= r != 2;
					c.rd = v1[3:0];
					c.data = v2;
					expected.push_back(c);
				end
				if (bad) begin
					$display("malformed entry for test %0s in tb/program_input.txt", name);
					$fclose(fd);
					return;
				end
			end else begin
				$display("unexpected token in tb/program_input.txt");
				$fclose(fd);
				return;
			end
		end
		$fclose(fd);
		ok = test_name.size() > 0;
	endtask

	task automatic run_test(input int t);
		int got;
		int cycles;
		int errs;
		int limit;
		logic [31:0] rnd;
		commit_t want;
		got = 0;
		cycles = 0;
		errs = 0;
		limit = 100 * word_count[t];
		// program load with one word per handshake
		for (int k = 0; k < word_count[t]; k++) begin
			load_data = words[word_first[t] + k];
			load_valid = 1'b1;
			while (!load_ready) begin
				next_cycle();
			end
			next_cycle();
		end
		load_valid = 1'b0;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		while (!done && cycles < limit) begin
			rnd = $urandom();
			commit_ready = test_bp[t] != 0 ? rnd[0] : 1'b1;
			if (commit_valid && commit_ready) begin
				if (got >= exp_count[t]) begin
					$display("test %0s: commit beyond the %0d expected", test_name[t],
						exp_count[t]);
					errs++;
				end else begin
					want = expected[exp_first[t] + got];
					checks++;
					if (commit != want) begin
						$display("mismatch %0s commit %0d: expected %0d/%08h, actual %0d/%08h",
							test_name[t], got, want.rd, want.data, commit.rd, commit.data);
						errs++;
					end
				end
				got++;
			end
			next_cycle();
			cycles++;
		end
		if (!done) begin
			$display("test %0s: done did not rise within %0d cycles", test_name[t], limit);
			errs++;
			hung = 1'b1;
		end else if (got != exp_count[t]) begin
			$display("test %0s: %0d commits arrived but %0d were expected", test_name[t],
				got, exp_count[t]);
			errs++;
		end
		commit_ready = 1'b1;
		errors += errs;
		if (errs == 0) begin
			passed++;
			$display("test %0s: ok, %0d commits in %0d cycles", test_name[t], got, cycles);
		end else begin
			failed++;
			$display("test %0s: failed with %0d errors", test_name[t], errs);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		bit ok;
		rst_n = 1'b0;
		load_data = '0;
		load_valid = 1'b0;
		start = 1'b0;
		commit_ready = 1'b0;
		parsed = 1'b0;
		hung = 1'b0;
		errors = 0;
		checks = 0;
		passed = 0;
		failed = 0;
		void'($urandom(32996));
		read_tests(ok);
		if (ok) begin
			parsed = 1'b1;
			repeat (4) @(posedge clk);
			#drive_delay;
			rst_n = 1'b1;
			for (int t = 0; t < test_name.size() && !hung; t++) begin
				run_test(t);
			end
			$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
				test_name.size(), passed, failed, checks, errors);
		end else begin
			$display("no test could be read from tb/program_input.txt");
		end
		if (ok && errors == 0 && !hung) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// budget scales with the program sizes
	initial begin
		wait (parsed);
		repeat (cycles_per_word * total_words) @(posedge clk);
		$display("watchdog expired after %0d cycles", cycles_per_word * total_words);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core #(
	parameter int rob_width = ooo_pkg::default_rob_width,
	parameter int inst_mem_width = ooo_pkg::default_inst_mem_width,
	parameter int rs_depth = ooo_pkg::default_rs_depth
) (
	input wire clk,
	input wire rst_n,
	input wire [ooo_pkg::xlen-1:0] load_data,
	input wire load_valid,
	input wire start,
	input wire commit_ready,
	output logic load_ready,
	output ooo_pkg::commit_t commit,
	output logic commit_valid,
	output logic done
);
	import ooo_pkg::*;

	inst_t inst;
	logic [inst_mem_width-1:0] pc;
	logic exec_mode;
	logic exec_mode_next;
	logic first_wait;
	logic halt_seen;
	logic start_ok;
	logic exec;
	logic load_fire;
	logic rob_empty;
	logic rob_issue_ready;
	logic rs_issue_ready;
	logic want_issue;
	logic issue_valid;
	logic [rob_width-1:0] issue_tag;
	logic [rob_width-1:0] commit_tag;
	cdb_t arch_read [2];
	rob_read_t rob_read [2];
	logic [rob_width-1:0] rob_read_tag [2];
	cdb_t operand [2];
	cdb_t cdb;

	////////////////////
	// mode
	////////////////////

	assign start_ok = start && !exec_mode;
	assign load_fire = load_valid && load_ready;
	// first execute cycle only fetches
	assign exec = exec_mode && !first_wait;

	always_comb begin
		exec_mode_next = exec_mode;
		if (start_ok) begin
			exec_mode_next = 1'b1;
		end else if (exec_mode && halt_seen && rob_empty) begin
			exec_mode_next = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exec_mode <= 1'b0;
			first_wait <= 1'b0;
			load_ready <= 1'b0;
			done <= 1'b0;
		end else begin
			exec_mode <= exec_mode_next;
			first_wait <= start_ok;
			load_ready <= !exec_mode_next;
			if (exec_mode && !exec_mode_next) begin
				done <= 1'b1;
			end else if (load_fire) begin
				done <= 1'b0;
			end
		end
	end

	// set by halt or by issue of the last memory word with pc wrapped to 0
	always_ff @(posedge clk) begin
		if (!rst_n || start_ok) begin
			halt_seen <= 1'b0;
		end else if (exec && (inst.r.op == OP_HALT || (issue_valid && pc == '0))) begin
			halt_seen <= 1'b1;
		end
	end

	////////////////////
	// issue
	////////////////////

	assign want_issue = exec && !halt_seen && inst.r.op != OP_HALT;
	assign issue_valid = want_issue && rob_issue_ready && rs_issue_ready;

	// merge order is architectural value then reorder buffer then bus
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			rob_read_tag[k] = arch_read[k].tag;
			operand[k].tag = arch_read[k].tag;
			operand[k].valid = arch_read[k].valid || rob_read[k].valid ||
			                   (cdb.valid && cdb.tag == arch_read[k].tag);
			operand[k].data = arch_read[k].valid ? arch_read[k].data :
			                  rob_read[k].valid ? rob_read[k].data : cdb.data;
		end
	end

	////////////////////
	// units
	////////////////////

	inst_mem #(.inst_mem_width(inst_mem_width)) inst_mem (
		.clk,
		.rst_n,
		.we(load_fire),
		.wdata(load_data),
		.reset_pc(start_ok),
		.stall(!(first_wait || issue_valid)),
		.inst,
		.pc
	);

	register_file #(.rob_width(rob_width)) register_file (
		.clk,
		.rst_n,
		.inst,
		.issue(issue_valid),
		.issue_tag,
		.commit(commit_valid && commit_ready),
		.commit_rd(commit.rd),
		.commit_tag,
		.commit_data(commit.data),
		.read(arch_read)
	);

	rob #(.rob_width(rob_width)) rob (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_rd(inst.r.rd),
		.read_tag(rob_read_tag),
		.cdb,
		.commit_ready,
		.issue_ready(rob_issue_ready),
		.issue_tag,
		.read(rob_read),
		.commit,
		.commit_valid,
		.commit_tag,
		.empty(rob_empty)
	);

	add_sub #(.rob_width(rob_width), .rs_depth(rs_depth)) add_sub (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_op(inst.r.op),
		.issue_tag,
		.src(operand),
		.cdb,
		.issue_ready(rs_issue_ready),
		.cdb_out(cdb)
	);

endmodule

`default_nettype wire

// ==== design/add_sub.sv ====
`timescale 1ns/10ps
`default_nettype none

module add_sub #(
	parameter int rob_width = ooo_pkg::default_rob_width,
	parameter int rs_depth = ooo_pkg::default_rs_depth
) (
	input wire clk,
	input wire rst_n,
	input wire issue_valid,
	input wire ooo_pkg::op_t issue_op,
	input wire [rob_width-1:0] issue_tag,
	input wire ooo_pkg::cdb_t src [2],
	input wire ooo_pkg::cdb_t cdb,
	output logic issue_ready,
	output ooo_pkg::cdb_t cdb_out
);
	import ooo_pkg::*;

	// station contents
	logic [rs_depth-1:0] busy;
	op_t op [rs_depth];
	logic [rob_width-1:0] dest [rs_depth];
	cdb_t opnd [rs_depth][2];

	logic [rs_depth-1:0] ready;
	logic [rs_depth-1:0] alloc;
	logic [rs_depth-1:0] grant;
	logic issue_fire;

	op_t sel_op;
	logic [rob_width-1:0] sel_tag;
	logic [xlen-1:0] sel_a;
	logic [xlen-1:0] sel_b;

	logic res_valid;
	logic [rob_width-1:0] res_tag;
	logic [xlen-1:0] res_data;

	assign issue_ready = !(&busy);
	assign issue_fire = issue_valid && issue_ready;

	always_comb begin
		for (int k = 0; k < rs_depth; k++) begin
			ready[k] = busy[k] && opnd[k][0].valid && opnd[k][1].valid;
		end
	end

	// lowest free and lowest ready slot
	assign alloc = ~busy & (busy + 1'b1);
	assign grant = ready & (~ready + 1'b1);

	always_comb begin
		sel_op = OP_ADD;
		sel_tag = '0;
		sel_a = '0;
		sel_b = '0;
		for (int k = 0; k < rs_depth; k++) begin
			if (grant[k]) begin
				sel_op = op[k];
				sel_tag = dest[k];
				sel_a = opnd[k][0].data;
				sel_b = opnd[k][1].data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			busy <= (busy & ~grant) | (issue_fire ? alloc : '0);
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < rs_depth; k++) begin
			if (issue_fire && alloc[k]) begin
				op[k] <= issue_op;
				dest[k] <= issue_tag;
				opnd[k] <= src;
			end else begin
				// snoop the bus for missing operands
				for (int j = 0; j < 2; j++) begin
					if (!opnd[k][j].valid && cdb.valid && cdb.tag == opnd[k][j].tag) begin
						opnd[k][j].valid <= 1'b1;
						opnd[k][j].data <= cdb.data;
					end
				end
			end
		end
	end

	////////////////////
	// result stage
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= |ready;
		end
	end

	always_ff @(posedge clk) begin
		if (|ready) begin
			res_tag <= sel_tag;
			res_data <= sel_op == OP_SUB ? sel_a - sel_b : sel_a + sel_b;
		end
	end

	assign cdb_out.valid = res_valid;
	assign cdb_out.tag = res_tag;
	assign cdb_out.data = res_data;

endmodule

`default_nettype wire

// ==== design/rob.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob #(
	parameter int rob_width = ooo_pkg::default_rob_width
) (
	input wire clk,
	input wire rst_n,
	input wire issue_valid,
	input wire ooo_pkg::reg_idx_t issue_rd,
	input wire [rob_width-1:0] read_tag [2],
	input wire ooo_pkg::cdb_t cdb,
	input wire commit_ready,
	output logic issue_ready,
	output logic [rob_width-1:0] issue_tag,
	output ooo_pkg::rob_read_t read [2],
	output ooo_pkg::commit_t commit,
	output logic commit_valid,
	output logic [rob_width-1:0] commit_tag,
	output logic empty
);
	import ooo_pkg::*;

	localparam int depth = 1 << rob_width;

	logic [rob_width-1:0] head;
	logic [rob_width-1:0] tail;
	logic [rob_width:0] count;
	logic [depth-1:0] done;
	reg_idx_t dest [depth];
	logic [xlen-1:0] value [depth];

	logic issue_fire;
	logic commit_fire;

	////////////////////
	// issue
	////////////////////

	// top bit of count set only when every entry is taken
	assign issue_ready = !count[rob_width];
	assign issue_tag = tail;
	assign issue_fire = issue_valid && issue_ready;

	////////////////////
	// commit
	////////////////////

	assign empty = count == '0;
	assign commit_valid = !empty && done[head];
	assign commit_fire = commit_valid && commit_ready;
	assign commit_tag = head;
	assign commit.rd = dest[head];
	assign commit.data = value[head];

	// forwarding for operands still named by tag
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			read[k].valid = done[read_tag[k]];
			read[k].data = value[read_tag[k]];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (issue_fire) begin
				tail <= tail + 1'b1;
			end
			if (commit_fire) begin
				head <= head + 1'b1;
			end
			case ({issue_fire, commit_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// a fresh entry starts not done
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= '0;
		end else begin
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
			if (issue_fire) begin
				done[tail] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			value[cdb.tag] <= cdb.data;
		end
		if (issue_fire) begin
			dest[tail] <= issue_rd;
		end
	end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file #(
	parameter int rob_width = ooo_pkg::default_rob_width
) (
	input wire clk,
	input wire rst_n,
	input wire ooo_pkg::inst_t inst,
	input wire issue,
	input wire [rob_width-1:0] issue_tag,
	input wire commit,
	input wire ooo_pkg::reg_idx_t commit_rd,
	input wire [rob_width-1:0] commit_tag,
	input wire [ooo_pkg::xlen-1:0] commit_data,
	output ooo_pkg::cdb_t read [2]
);
	import ooo_pkg::*;

	logic [xlen-1:0] regs [reg_num];
	logic [reg_num-1:0] busy;
	logic [rob_width-1:0] busy_tag [reg_num];

	reg_idx_t src_idx [2];
	logic is_imm;
	logic rename;

	assign is_imm = inst.r.op == OP_ADDI;
	assign rename = issue && inst.r.rd != '0;

	// rs1 sits at the same bits in both views
	assign src_idx[0] = inst.r.rs1;
	assign src_idx[1] = inst.r.rs2;

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			read[k].tag = busy_tag[src_idx[k]];
			read[k].valid = src_idx[k] == '0 || !busy[src_idx[k]];
			read[k].data = src_idx[k] == '0 ? '0 : regs[src_idx[k]];
		end
		if (is_imm) begin
			read[1].valid = 1'b1;
			read[1].tag = '0;
			read[1].data = {{(xlen-16){inst.i.imm[15]}}, inst.i.imm};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			for (int k = 0; k < reg_num; k++) begin
				regs[k] <= '0;
			end
		end else begin
			if (commit && commit_rd != '0) begin
				regs[commit_rd] <= commit_data;
				// only the latest rename releases the register
				if (busy_tag[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end
			if (rename) begin
				busy[inst.r.rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rename) begin
			busy_tag[inst.r.rd] <= issue_tag;
		end
	end

endmodule

`default_nettype wire

// ==== design/inst_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_mem #(
	parameter int inst_mem_width = ooo_pkg::default_inst_mem_width
) (
	input wire clk,
	input wire rst_n,
	input wire we,
	input wire [ooo_pkg::xlen-1:0] wdata,
	input wire reset_pc,
	input wire stall,
	output ooo_pkg::inst_t inst,
	output logic [inst_mem_width-1:0] pc
);
	import ooo_pkg::*;

	localparam int depth = 1 << inst_mem_width;

	inst_t mem [depth];
	logic [inst_mem_width-1:0] waddr;

	////////////////////
	// load side
	////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// words land at consecutive addresses from 0
	always_ff @(posedge clk) begin
		if (!rst_n || reset_pc) begin
			waddr <= '0;
		end else if (we) begin
			waddr <= waddr + 1'b1;
		end
	end

	////////////////////
	// fetch side
	////////////////////

	// pc points at the next word to fetch
	always_ff @(posedge clk) begin
		if (!rst_n || reset_pc) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	// held while the issue stage is blocked
	always_ff @(posedge clk) begin
		if (!stall) begin
			inst <= mem[pc];
		end
	end

endmodule

`default_nettype wire

// ==== design/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int xlen = 32;

	// register 0 reads as zero and is never renamed
	localparam int reg_num = 16;

	// reorder buffer of 2**width entries
	localparam int default_rob_width = 3;
	localparam int default_inst_mem_width = 6;
	localparam int default_rs_depth = 2;

	typedef logic [$clog2(reg_num)-1:0] reg_idx_t;

	////////////////////
	// instruction word
	////////////////////

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_ADDI,
		OP_HALT
	} op_t;

	typedef struct packed {
		op_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [17:0] pad;
	} r_type_t;

	// immediate in the low half is sign extended at decode
	typedef struct packed {
		op_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		logic [5:0] pad;
		logic [15:0] imm;
	} i_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
	} inst_t;

	////////////////////
	// datapath bundles
	////////////////////

	// valid data or the tag of the pending producer
	typedef struct packed {
		logic valid;
		logic [default_rob_width-1:0] tag;
		logic [xlen-1:0] data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] data;
	} rob_read_t;

	typedef struct packed {
		reg_idx_t rd;
		logic [xlen-1:0] data;
	} commit_t;

endpackage

`default_nettype wire
